/* src/isa_pkg.sv */
// ------------------------------
// instruction encoding of the core
// field positions, primary and secondary opcodes, ALU select
// imported by decode, execute and the testbench
// ------------------------------
package isa_pkg;

  // bit ranges inside a 32-bit instruction word
  localparam int op1_hi = 31;
  localparam int op1_lo = 26;
  localparam int op2_hi = 25;
  localparam int op2_lo = 18;
  localparam int imm_hi = 23;   // overlaps op2, only used by immediate forms
  localparam int imm_lo = 8;
  localparam int rd_hi  = 11;
  localparam int rd_lo  = 8;
  localparam int rs_hi  = 7;
  localparam int rs_lo  = 4;
  localparam int rt_hi  = 3;
  localparam int rt_lo  = 0;

  typedef enum logic [5:0] {
    op1_alur = 6'b000000,   // register group, op2 picks the operation
    op1_beq  = 6'b001000,
    op1_blt  = 6'b001001,
    op1_bne  = 6'b001011,
    op1_jal  = 6'b001100,
    op1_lw   = 6'b010010,
    op1_sw   = 6'b011010,
    op1_addi = 6'b100000,
    op1_andi = 6'b100100,
    op1_ori  = 6'b100101,
    op1_xori = 6'b100110
  } op1_e;

  typedef enum logic [7:0] {
    op2_eq  = 8'b00001000,
    op2_lt  = 8'b00001001,
    op2_add = 8'b00100000,
    op2_and = 8'b00100100,
    op2_or  = 8'b00100101,
    op2_xor = 8'b00100110,
    op2_sub = 8'b00101000
  } op2_e;

  // operation chosen in decode, applied in execute
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_eq,
    alu_lt,   // signed
    alu_ne
  } alu_op_e;

endpackage

/* src/core_cfg_pkg.sv */
// ------------------------------
// datapath sizes of the core and the APB phase encoding
// imported by every pipeline stage
// ------------------------------
package core_cfg_pkg;

  localparam int data_bits   = 32;
  localparam int reg_no_bits = 4;   // sixteen registers

  // pc step per instruction, in bytes
  localparam logic [data_bits-1:0] inst_size = 4;

  // phase seen on the APB requester
  typedef enum logic [1:0] {
    idle,
    setup,
    access
  } apb_phase_e;

endpackage

/* src/fetch_unit.sv */
// ------------------------------
// fetch stage, program counter and fetch buffer
// imem answers in the same cycle as imem_addr
// ------------------------------
`timescale 1ns/1ps

module fetch_unit import core_cfg_pkg::*; #(
  parameter logic [data_bits-1:0] start_pc = '0
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 data_stall,
  input  logic                 ctrl_stall,
  input  logic                 mem_wait,
  input  logic                 redirect,
  input  logic [data_bits-1:0] new_pc,
  input  logic [data_bits-1:0] imem_data,
  output logic [data_bits-1:0] imem_addr,
  output logic [data_bits-1:0] fe_pc,
  output logic [data_bits-1:0] fe_inst
);

  logic [data_bits-1:0] pc;

  assign imem_addr = pc;

  // an all-zero word decodes as a bubble
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc      <= start_pc;
      fe_pc   <= '0;
      fe_inst <= '0;
    end else if (!(mem_wait || data_stall)) begin   // both freeze the whole stage
      if (redirect) begin
        pc      <= new_pc;
        fe_inst <= '0;
      end else if (ctrl_stall) begin
        fe_inst <= '0;   // pc waits for the branch outcome
      end else begin
        pc      <= pc + inst_size;
        fe_pc   <= pc;
        fe_inst <= imem_data;
      end
    end
  end

endmodule

/* src/decode_unit.sv */
// ------------------------------
// decode stage with hazard detection and operand forwarding
// forwards from execute first, then from the memory stage
// ------------------------------
`timescale 1ns/1ps

module decode_unit import isa_pkg::*, core_cfg_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [data_bits-1:0]   fe_pc,
  input  logic [data_bits-1:0]   fe_inst,
  input  logic [data_bits-1:0]   rs_val,
  input  logic [data_bits-1:0]   rt_val,
  input  logic [data_bits-1:0]   ex_result,
  input  logic [data_bits-1:0]   mem_result,
  input  logic                   ex_has_dest,
  input  logic [reg_no_bits-1:0] ex_dest,
  input  logic                   mem_wait,
  input  logic                   redirect,
  output logic [reg_no_bits-1:0] rs_idx,
  output logic [reg_no_bits-1:0] rt_idx,
  output logic                   data_stall,
  output logic                   ctrl_stall,
  output logic [data_bits-1:0]   de_pc,
  output alu_op_e                de_alu_op,
  output logic                   de_use_imm,
  output logic                   de_is_branch,
  output logic                   de_is_jal,
  output logic                   de_is_load,
  output logic                   de_is_store,
  output logic                   de_has_dest,
  output logic [reg_no_bits-1:0] de_dest,
  output logic [data_bits-1:0]   de_imm,
  output logic [data_bits-1:0]   de_rs_val,
  output logic [data_bits-1:0]   de_rt_val
);

  localparam int imm_bits = imm_hi - imm_lo + 1;

  op1_e                   op1;
  op2_e                   op2;
  logic [imm_bits-1:0]    imm;
  logic [reg_no_bits-1:0] rd_idx;
  logic [data_bits-1:0]   sxt_imm;
  logic [data_bits-1:0]   rs_fwd;
  logic [data_bits-1:0]   rt_fwd;
  alu_op_e                alu_op;
  logic use_imm, is_branch, is_jal, is_load, is_store;
  logic has_dest, uses_rs, uses_rt;

  assign op1     = op1_e'(fe_inst[op1_hi:op1_lo]);
  assign op2     = op2_e'(fe_inst[op2_hi:op2_lo]);
  assign imm     = fe_inst[imm_hi:imm_lo];
  assign rd_idx  = fe_inst[rd_hi:rd_lo];
  assign rs_idx  = fe_inst[rs_hi:rs_lo];
  assign rt_idx  = fe_inst[rt_hi:rt_lo];
  assign sxt_imm = {{(data_bits - imm_bits){imm[imm_bits-1]}}, imm};

  always_comb begin
    alu_op    = alu_add;
    use_imm   = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    has_dest  = 1'b0;
    uses_rs   = 1'b0;
    uses_rt   = 1'b0;
    case (op1)
      op1_alur: begin
        has_dest = 1'b1;
        uses_rs  = 1'b1;
        uses_rt  = 1'b1;
        case (op2)
          op2_add: alu_op = alu_add;
          op2_sub: alu_op = alu_sub;
          op2_and: alu_op = alu_and;
          op2_or:  alu_op = alu_or;
          op2_xor: alu_op = alu_xor;
          op2_eq:  alu_op = alu_eq;
          op2_lt:  alu_op = alu_lt;
          default: begin   // unknown op2, the zero bubble lands here
            has_dest = 1'b0;
            uses_rs  = 1'b0;
            uses_rt  = 1'b0;
          end
        endcase
      end
      op1_beq, op1_bne, op1_blt: begin
        is_branch = 1'b1;
        uses_rs   = 1'b1;
        uses_rt   = 1'b1;
        alu_op    = (op1 == op1_beq) ? alu_eq : (op1 == op1_bne) ? alu_ne : alu_lt;
      end
      op1_jal: begin
        is_jal   = 1'b1;
        has_dest = 1'b1;
        uses_rs  = 1'b1;
      end
      op1_lw, op1_sw: begin
        is_load  = (op1 == op1_lw);
        is_store = (op1 == op1_sw);
        has_dest = (op1 == op1_lw);
        use_imm  = 1'b1;
        uses_rs  = 1'b1;
        uses_rt  = (op1 == op1_sw);   // store data
      end
      op1_addi, op1_andi, op1_ori, op1_xori: begin
        has_dest = 1'b1;
        use_imm  = 1'b1;
        uses_rs  = 1'b1;
        alu_op   = (op1 == op1_addi) ? alu_add :
                   (op1 == op1_andi) ? alu_and :
                   (op1 == op1_ori)  ? alu_or  : alu_xor;
      end
      default: ;
    endcase
  end

  // a load in execute has no value yet, so it never forwards
  assign rs_fwd = (de_has_dest && !de_is_load && de_dest == rs_idx) ? ex_result  :
                  (ex_has_dest && ex_dest == rs_idx)                ? mem_result : rs_val;
  assign rt_fwd = (de_has_dest && !de_is_load && de_dest == rt_idx) ? ex_result  :
                  (ex_has_dest && ex_dest == rt_idx)                ? mem_result : rt_val;

  assign data_stall = de_is_load && de_has_dest &&
                      ((uses_rs && rs_idx == de_dest) || (uses_rt && rt_idx == de_dest));

  // held from decode until the branch or jal leaves execute
  assign ctrl_stall = is_branch | is_jal | de_is_branch | de_is_jal;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      de_is_branch <= 1'b0;
      de_is_jal    <= 1'b0;
      de_is_load   <= 1'b0;
      de_is_store  <= 1'b0;
      de_has_dest  <= 1'b0;
    end else if (!mem_wait) begin
      de_is_branch <= is_branch & ~(redirect | data_stall);
      de_is_jal    <= is_jal    & ~(redirect | data_stall);
      de_is_load   <= is_load   & ~(redirect | data_stall);
      de_is_store  <= is_store  & ~(redirect | data_stall);
      de_has_dest  <= has_dest  & ~(redirect | data_stall);
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_wait) begin
      de_pc      <= fe_pc;
      de_alu_op  <= alu_op;
      de_use_imm <= use_imm;
      de_dest    <= (op1 == op1_alur) ? rd_idx : rt_idx;   // rt for immediate forms
      de_imm     <= sxt_imm;
      de_rs_val  <= rs_fwd;
      de_rt_val  <= rt_fwd;
    end
  end

endmodule

/* src/reg_file.sv */
// ------------------------------
// register file, two reads and one write
// a read of the register being written sees the new value
// ------------------------------
`timescale 1ns/1ps

module reg_file import core_cfg_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [reg_no_bits-1:0] rs_idx,
  input  logic [reg_no_bits-1:0] rt_idx,
  input  logic                   wr_en,
  input  logic [reg_no_bits-1:0] wr_idx,
  input  logic [data_bits-1:0]   wr_data,
  output logic [data_bits-1:0]   rs_val,
  output logic [data_bits-1:0]   rt_val
);

  localparam int reg_words = 1 << reg_no_bits;

  logic [data_bits-1:0] regs [reg_words];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < reg_words; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // write-through bypass
  assign rs_val = (wr_en && wr_idx == rs_idx) ? wr_data : regs[rs_idx];
  assign rt_val = (wr_en && wr_idx == rt_idx) ? wr_data : regs[rt_idx];

endmodule

/* src/execute_unit.sv */
// ------------------------------
// execute stage, ALU, branch decision and jump targets
// the execute buffer feeds the APB data port
// ------------------------------
`timescale 1ns/1ps

module execute_unit import isa_pkg::*, core_cfg_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [data_bits-1:0]   de_pc,
  input  alu_op_e                de_alu_op,
  input  logic                   de_use_imm,
  input  logic                   de_is_branch,
  input  logic                   de_is_jal,
  input  logic                   de_is_load,
  input  logic                   de_is_store,
  input  logic                   de_has_dest,
  input  logic [reg_no_bits-1:0] de_dest,
  input  logic [data_bits-1:0]   de_imm,
  input  logic [data_bits-1:0]   de_rs_val,
  input  logic [data_bits-1:0]   de_rt_val,
  input  logic                   mem_wait,
  output logic [data_bits-1:0]   ex_result,
  output logic                   redirect,
  output logic [data_bits-1:0]   new_pc,
  output logic                   ex_is_load,
  output logic                   ex_is_store,
  output logic                   ex_has_dest,
  output logic [reg_no_bits-1:0] ex_dest,
  output logic [data_bits-1:0]   ex_addr,
  output logic [data_bits-1:0]   ex_store_data
);

  logic signed [data_bits-1:0] op_a;
  logic signed [data_bits-1:0] op_b;
  logic        [data_bits-1:0] alu_out;
  logic        [data_bits-1:0] link_pc;
  logic                        taken;

  assign op_a = de_rs_val;
  assign op_b = de_use_imm ? de_imm : de_rt_val;

  always_comb begin
    case (de_alu_op)
      alu_add: alu_out = op_a + op_b;
      alu_sub: alu_out = op_a - op_b;
      alu_and: alu_out = op_a & op_b;
      alu_or:  alu_out = op_a | op_b;
      alu_xor: alu_out = op_a ^ op_b;
      alu_eq:  alu_out = {{(data_bits-1){1'b0}}, op_a == op_b};
      alu_lt:  alu_out = {{(data_bits-1){1'b0}}, op_a < op_b};   // signed operands
      alu_ne:  alu_out = {{(data_bits-1){1'b0}}, op_a != op_b};
      default: alu_out = '0;
    endcase
  end

  assign link_pc   = de_pc + inst_size;
  assign ex_result = de_is_jal ? link_pc : alu_out;

  assign taken    = de_is_branch && alu_out[0];
  assign redirect = de_is_jal || taken;

  // jal is register relative, branches are pc relative
  assign new_pc = de_is_jal ? (de_imm << 2) + de_rs_val : link_pc + (de_imm << 2);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_is_load  <= 1'b0;
      ex_is_store <= 1'b0;
      ex_has_dest <= 1'b0;
    end else if (!mem_wait) begin
      ex_is_load  <= de_is_load;
      ex_is_store <= de_is_store;
      ex_has_dest <= de_has_dest;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_wait) begin
      ex_dest       <= de_dest;
      ex_addr       <= ex_result;   // load/store address or ALU result
      ex_store_data <= de_rt_val;
    end
  end

endmodule

/* src/apb_data_port.sv */
// ------------------------------
// memory stage, APB requester for loads and stores
// holds the pipeline with mem_wait until pready ends the access
// ------------------------------
`timescale 1ns/1ps

module apb_data_port import core_cfg_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   ex_is_load,
  input  logic                   ex_is_store,
  input  logic                   ex_has_dest,
  input  logic [reg_no_bits-1:0] ex_dest,
  input  logic [data_bits-1:0]   ex_addr,
  input  logic [data_bits-1:0]   ex_store_data,
  input  logic [data_bits-1:0]   prdata,
  input  logic                   pready,
  output logic                   psel,
  output logic                   penable,
  output logic                   pwrite,
  output logic [data_bits-1:0]   paddr,
  output logic [data_bits-1:0]   pwdata,
  output logic                   mem_wait,
  output logic [data_bits-1:0]   mem_result,
  output logic                   wr_en,
  output logic [reg_no_bits-1:0] wr_idx,
  output logic [data_bits-1:0]   wr_data
);

  apb_phase_e phase_q;      // idle or access
  apb_phase_e phase;        // phase on the bus this cycle
  apb_phase_e phase_next;
  logic       gap_q;        // forced idle cycle after a completed access
  logic       mem_op;
  logic       done;

  assign mem_op = ex_is_load | ex_is_store;

  // setup starts in the first cycle a load or store sits in this stage
  always_comb begin
    if (phase_q == access) phase = access;
    else if (mem_op && !gap_q) phase = setup;
    else phase = idle;
  end

  assign done = (phase == access) && pready;

  always_comb begin
    case (phase)
      setup:   phase_next = access;
      access:  phase_next = pready ? idle : access;
      default: phase_next = idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      phase_q <= idle;
      gap_q   <= 1'b0;
    end else begin
      phase_q <= phase_next;
      gap_q   <= done;
    end
  end

  assign psel     = (phase != idle);
  assign penable  = (phase == access);
  assign pwrite   = psel & ex_is_store;
  assign paddr    = ex_addr;         // stable, execute buffer holds on mem_wait
  assign pwdata   = ex_store_data;
  assign mem_wait = mem_op && !done;

  assign mem_result = (ex_is_load && done) ? prdata : ex_addr;

  // memory buffer, drives the register write
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= ex_has_dest & ~mem_wait;   // bubble while waiting
    end
  end

  always_ff @(posedge clk) begin
    wr_idx  <= ex_dest;
    wr_data <= mem_result;
  end

endmodule

/* src/pipeline_core.sv */
// ------------------------------
// five stage core, top level
// instruction read port plus an APB requester for data
// ------------------------------
`timescale 1ns/1ps

module pipeline_core import isa_pkg::*, core_cfg_pkg::*; #(
  parameter logic [data_bits-1:0] start_pc = 256
) (
  input  logic                 clk,
  input  logic                 reset,
  output logic [data_bits-1:0] imem_addr,
  input  logic [data_bits-1:0] imem_data,
  output logic                 psel,
  output logic                 penable,
  output logic                 pwrite,
  output logic [data_bits-1:0] paddr,
  output logic [data_bits-1:0] pwdata,
  input  logic [data_bits-1:0] prdata,
  input  logic                 pready
);

  // stall and redirect
  logic                   data_stall, ctrl_stall, mem_wait, redirect;
  logic [data_bits-1:0]   new_pc;

  logic [data_bits-1:0]   fe_pc, fe_inst;
  logic [reg_no_bits-1:0] rs_idx, rt_idx;
  logic [data_bits-1:0]   rs_val, rt_val;

  logic [data_bits-1:0]   de_pc, de_imm, de_rs_val, de_rt_val;
  alu_op_e                de_alu_op;
  logic                   de_use_imm, de_is_branch, de_is_jal;
  logic                   de_is_load, de_is_store, de_has_dest;
  logic [reg_no_bits-1:0] de_dest;

  logic [data_bits-1:0]   ex_result, ex_addr, ex_store_data;
  logic                   ex_is_load, ex_is_store, ex_has_dest;
  logic [reg_no_bits-1:0] ex_dest;

  logic [data_bits-1:0]   mem_result, wr_data;
  logic                   wr_en;
  logic [reg_no_bits-1:0] wr_idx;

  fetch_unit #(.start_pc(start_pc)) u_fetch (.*);

  decode_unit u_decode (.*);

  reg_file u_regs (.*);

  execute_unit u_execute (.*);

  apb_data_port u_mem (.*);

endmodule

/* bench/clock_gen.sv */
// ------------------------------
// testbench clock, 100 ns period
// reset held high for the first two rising edges
// ------------------------------
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (2) @(posedge clk);
    reset <= 1'b0;   // released on the second rising edge
  end

endmodule

/* bench/core_sva.sv */
// ------------------------------
// APB protocol and fetch address properties
// bound into pipeline_core
// ------------------------------
`timescale 1ns/1ps

module core_sva import core_cfg_pkg::*; #(
  parameter logic [data_bits-1:0] start_pc = 256
) (
  input logic                 clk,
  input logic                 reset,
  input logic [data_bits-1:0] imem_addr,
  input logic                 psel,
  input logic                 penable,
  input logic                 pwrite,
  input logic [data_bits-1:0] paddr,
  input logic [data_bits-1:0] pwdata,
  input logic                 pready,
  input logic                 mem_wait,
  input logic                 data_stall,
  input logic                 ctrl_stall,
  input logic                 redirect,
  input logic [data_bits-1:0] new_pc
);

  logic failed = 1'b0;

  a_reset_pc: assert property (@(posedge clk) reset |=> imem_addr == start_pc)
    else begin
      $error("fetch address is not the start address after a reset cycle");
      failed = 1'b1;
    end

  // first fetches after reset, one word apart
  a_first_fetches: assert property (@(posedge clk)
    $fell(reset) |-> imem_addr == start_pc ##1 imem_addr == start_pc + inst_size
                     ##1 imem_addr == start_pc + 2 * inst_size)
    else begin
      $error("first fetches after reset do not step by one word");
      failed = 1'b1;
    end

  a_pc_step: assert property (@(posedge clk) disable iff (reset)
    !reset && !(mem_wait || data_stall || ctrl_stall || redirect)
      |=> imem_addr == $past(imem_addr) + inst_size)
    else begin
      $error("fetch address did not advance by one word");
      failed = 1'b1;
    end

  a_pc_hold: assert property (@(posedge clk) disable iff (reset)
    !reset && (mem_wait || data_stall) |=> $stable(imem_addr))
    else begin
      $error("fetch address moved during a stall");
      failed = 1'b1;
    end

  a_pc_redirect: assert property (@(posedge clk) disable iff (reset)
    !reset && redirect && !mem_wait && !data_stall |=> imem_addr == $past(new_pc))
    else begin
      $error("fetch address did not follow the redirect");
      failed = 1'b1;
    end

  a_setup_first: assert property (@(posedge clk) disable iff (reset)
    $rose(penable) |-> $past(psel))
    else begin
      $error("penable rose without a setup cycle");
      failed = 1'b1;
    end

  a_setup_access: assert property (@(posedge clk) disable iff (reset)
    psel && !penable |=> penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    else begin
      $error("setup not followed by a stable access phase");
      failed = 1'b1;
    end

  a_access_hold: assert property (@(posedge clk) disable iff (reset)
    penable && !pready |=> penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    else begin
      $error("APB request changed while waiting for pready");
      failed = 1'b1;
    end

endmodule

bind pipeline_core core_sva #(.start_pc(start_pc)) u_core_sva (
  .clk        (clk),
  .reset      (reset),
  .imem_addr  (imem_addr),
  .psel       (psel),
  .penable    (penable),
  .pwrite     (pwrite),
  .paddr      (paddr),
  .pwdata     (pwdata),
  .pready     (pready),
  .mem_wait   (mem_wait),
  .data_stall (data_stall),
  .ctrl_stall (ctrl_stall),
  .redirect   (redirect),
  .new_pc     (new_pc)
);

/* bench/tb_top.sv */
// ------------------------------
// testbench for the five stage core
// program ROM on the fetch port, APB memory with random wait states
// store values are checked as each store completes
// ------------------------------
`timescale 1ns/1ps

module tb_top import isa_pkg::*, core_cfg_pkg::*; ();

  localparam logic [15:0] jal_imm    = 16'd84;
  localparam logic [31:0] jal_addr   = 32'h134;
  localparam logic [31:0] jal_target = jal_imm * 4;   // rs is r0
  localparam int          n_stores   = 4;

  logic                 clk, reset;
  logic [data_bits-1:0] imem_addr, imem_data;
  logic                 psel, penable, pwrite;
  logic [data_bits-1:0] paddr, pwdata;
  logic [data_bits-1:0] prdata = '0;
  logic                 pready = 1'b0;

  logic [31:0] rom  [256];
  logic [31:0] dmem [64];
  logic [31:0] rng_state   = 32'd47;
  int unsigned wait_left   = 0;
  int unsigned stores_seen = 0;
  logic [31:0] prev_fetch  = '0;

  // bus as seen in the second half of each cycle
  logic        s_psel = 1'b0, s_penable = 1'b0, s_pwrite = 1'b0, s_pready = 1'b0;
  logic [31:0] s_paddr = '0, s_pwdata = '0;

  clock_gen u_clk (.clk(clk), .reset(reset));

  pipeline_core DUT (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready)
  );

  assign imem_data = rom[imem_addr[9:2]];   // combinational read port

  function automatic logic [31:0] i_form(input op1_e op, input logic [3:0] rs,
                                         input logic [3:0] rt, input logic [15:0] imm);
    logic [31:0] w;
    w = '0;
    w[op1_hi:op1_lo] = op;
    w[imm_hi:imm_lo] = imm;
    w[rs_hi:rs_lo]   = rs;
    w[rt_hi:rt_lo]   = rt;
    return w;
  endfunction

  function automatic logic [31:0] r_form(input op2_e op, input logic [3:0] rd,
                                         input logic [3:0] rs, input logic [3:0] rt);
    logic [31:0] w;
    w = '0;
    w[op1_hi:op1_lo] = op1_alur;
    w[op2_hi:op2_lo] = op;
    w[rd_hi:rd_lo]   = rd;
    w[rs_hi:rs_lo]   = rs;
    w[rt_hi:rt_lo]   = rt;
    return w;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h0001_0003) ^ 32'h5A00_C3C3;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic expect_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp) else begin
      $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
    case (addr)
      32'd64: expect_value("alu_forward", 32'd12, data);               // 5 + 7
      32'd72: expect_value("load_use", fill_word(32'd128) - 32'd5, data);
      32'd76: expect_value("branch_fall_through", 32'h5A, data);
      32'd80: expect_value("jal_link", jal_addr + 32'd4, data);
      32'd68: abort_run("store to address 68 ran although beq or jal skips it");
      default: abort_run($sformatf("store to unexpected address 0x%08h", addr));
    endcase
  endtask

  task automatic place(input logic [31:0] addr, input logic [31:0] word);
    rom[addr[9:2]] = word;
  endtask

  task automatic load_program();
    place(32'h100, i_form(op1_addi, 0, 1, 16'd5));
    place(32'h104, i_form(op1_addi, 0, 2, 16'd7));
    place(32'h108, r_form(op2_add, 3, 1, 2));      // r1 from memory, r2 from execute
    place(32'h10C, i_form(op1_sw, 0, 3, 16'd64));
    place(32'h110, i_form(op1_lw, 0, 4, 16'd128));
    place(32'h114, r_form(op2_sub, 5, 4, 1));      // load-use bubble
    place(32'h118, i_form(op1_sw, 0, 5, 16'd72));
    place(32'h11C, i_form(op1_beq, 1, 1, 16'd1));  // taken, skips the next store
    place(32'h120, i_form(op1_sw, 0, 3, 16'd68));
    place(32'h124, i_form(op1_bne, 1, 1, 16'd2));  // a wrong take skips the marker
    place(32'h128, i_form(op1_blt, 2, 1, 16'd1));  // 7 < 5 is false
    place(32'h12C, i_form(op1_addi, 0, 6, 16'h5A));
    place(32'h130, i_form(op1_sw, 0, 6, 16'd76));
    place(jal_addr, i_form(op1_jal, 0, 7, jal_imm));
    place(32'h138, i_form(op1_sw, 0, 3, 16'd68)); // never fetched into decode
    place(jal_target, i_form(op1_sw, 0, 7, 16'd80));
  endtask

  always @(negedge clk) begin
    if (DUT.u_core_sva.failed)
      abort_run("a bound assertion on the APB port or the fetch address failed");
    if (!reset && prev_fetch == jal_addr + inst_size && imem_addr != prev_fetch)
      expect_value("jal_target", jal_target, imem_addr);
    prev_fetch = imem_addr;
    s_psel     = psel;
    s_penable  = penable;
    s_pwrite   = pwrite;
    s_pready   = pready;
    s_paddr    = paddr;
    s_pwdata   = pwdata;
  end

  // APB memory model
  always @(posedge clk) begin
    if (s_psel && !s_penable) begin
      rng_state = xorshift32(rng_state);
      wait_left = rng_state[1:0];   // 0 to 3 wait cycles
      prdata <= dmem[s_paddr[7:2]];
      pready <= (wait_left == 0);
    end else if (s_psel && s_penable && s_pready) begin
      pready <= 1'b0;
      if (s_pwrite) begin
        dmem[s_paddr[7:2]] <= s_pwdata;
        check_store(s_paddr, s_pwdata);
        stores_seen <= stores_seen + 1;
      end
    end else if (s_psel && s_penable) begin
      if (wait_left <= 1)
        pready <= 1'b1;
      wait_left = wait_left - 1;
    end
  end

  initial begin
    int cyc;
    for (int i = 0; i < 256; i++)
      rom[i] = '0;   // zero word runs as a bubble
    for (int i = 0; i < 64; i++)
      dmem[i] = fill_word(i * 4);
    load_program();

    cyc = 0;
    while (reset !== 1'b0 && cyc < 20) begin
      @(posedge clk);
      cyc++;
    end
    if (reset !== 1'b0)
      abort_run("reset was never released");

    cyc = 0;
    while (stores_seen < n_stores && cyc < 500) begin
      @(posedge clk);
      cyc++;
    end
    repeat (8) @(posedge clk);   // room for a stray access to show up

    if (stores_seen == n_stores) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("saw %0d of %0d expected stores before the timeout", stores_seen, n_stores);
      $display("Test FAILED");
      $fatal(1);
    end
  end

endmodule

/* tb.f */
src/isa_pkg.sv
src/core_cfg_pkg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/reg_file.sv
src/execute_unit.sv
src/apb_data_port.sv
src/pipeline_core.sv
bench/clock_gen.sv
bench/core_sva.sv
bench/tb_top.sv
